//--- logic/mem2r1w_pkg.sv
`default_nettype none

package mem2r1w_pkg;

  // data word and bank geometry
  localparam int WIDTH   = 16;
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  // virtual address is {row, bank} with the bank in the low bits
  localparam int BITADDR = 6;

  // parity bank sits right after the data banks
  localparam int NUMBANK = NUMVBNK + 1;

  localparam int NUMRDPT = 2;

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [BITADDR-1:0] vaddr_t;
  typedef logic [BITVBNK-1:0] vbank_t;
  typedef logic [BITVROW-1:0] vrow_t;

  typedef enum logic {
    INIT_SWEEP,
    INIT_DONE
  } init_state_t;

endpackage

`default_nettype wire

//--- logic/bank_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bank_if;
  import mem2r1w_pkg::*;

  logic  rd;
  vrow_t rd_row;
  logic  wr;
  vrow_t wr_row;
  word_t wdata;
  word_t rdata;  // valid the cycle after rd

  modport ram (
    input  rd, rd_row, wr, wr_row, wdata,
    output rdata
  );

  modport issue (
    output rd, rd_row, wr, wr_row, wdata
  );

  modport rd_req (
    output rd, rd_row
  );

  modport wr_req (
    output wr, wr_row, wdata
  );

  modport ret (
    input rdata
  );

endinterface

`default_nettype wire

//--- logic/bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bank_ram (
  input logic clk,
  bank_if.ram port
);
  import mem2r1w_pkg::*;

  word_t mem [NUMVROW];

  always_ff @(posedge clk) begin
    if (port.wr) begin
      mem[port.wr_row] <= port.wdata;
    end
  end

  // a read of the row being written returns the new word
  always_ff @(posedge clk) begin
    if (port.rd) begin
      if (port.wr && (port.wr_row == port.rd_row)) begin
        port.rdata <= port.wdata;
      end else begin
        port.rdata <= mem[port.rd_row];
      end
    end
  end

  a_rd_row_range: assert property (
    @(posedge clk) port.rd |-> (int'(port.rd_row) < NUMVROW)
  );

  a_wr_row_range: assert property (
    @(posedge clk) port.wr |-> (int'(port.wr_row) < NUMVROW)
  );

endmodule

`default_nettype wire

//--- logic/access_sched.sv
`timescale 1ns/1ps
`default_nettype none

module access_sched (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              write,
  input  mem2r1w_pkg::vaddr_t               wr_adr,
  input  mem2r1w_pkg::word_t                din,
  input  logic [mem2r1w_pkg::NUMRDPT-1:0]   read,
  input  mem2r1w_pkg::vaddr_t               rd_adr0,
  input  mem2r1w_pkg::vaddr_t               rd_adr1,
  output logic                              ready,
  bank_if.issue                             data_bank [mem2r1w_pkg::NUMVBNK],
  bank_if.rd_req                            par_rd,
  output logic                              upd,
  output mem2r1w_pkg::vbank_t               upd_bank,
  output mem2r1w_pkg::vrow_t                upd_row,
  output mem2r1w_pkg::word_t                upd_data,
  output logic [mem2r1w_pkg::NUMRDPT-1:0]   pend_vld,
  output logic [mem2r1w_pkg::NUMRDPT-1:0]   pend_rebuild,
  output mem2r1w_pkg::vbank_t               pend_bank0,
  output mem2r1w_pkg::vbank_t               pend_bank1
);
  import mem2r1w_pkg::*;

  init_state_t        init_state;
  vrow_t              init_row;
  logic               sweep;
  logic               wr_ok;
  logic [NUMRDPT-1:0] rd_ok;
  logic               rebuild;
  vbank_t             wr_bank;
  vbank_t             rd_bank0;
  vbank_t             rd_bank1;
  vrow_t              wr_row;
  vrow_t              rd_row0;
  vrow_t              rd_row1;
  logic [NUMVBNK-1:0] bank_rd;
  logic [NUMVBNK-1:0] bank_wr;
  vrow_t              bank_rd_row [NUMVBNK];
  vrow_t              bank_wr_row;
  word_t              bank_wdata;

  // one row of every data bank is zeroed per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      init_state <= INIT_SWEEP;
      init_row   <= '0;
    end else if (init_state == INIT_SWEEP) begin
      init_row <= init_row + 1'b1;
      if (init_row == vrow_t'(NUMVROW - 1)) begin
        init_state <= INIT_DONE;
      end
    end
  end

  assign sweep = (init_state == INIT_SWEEP);
  assign ready = (init_state == INIT_DONE);

  assign wr_bank  = wr_adr[BITVBNK-1:0];
  assign wr_row   = wr_adr[BITADDR-1:BITVBNK];
  assign rd_bank0 = rd_adr0[BITVBNK-1:0];
  assign rd_row0  = rd_adr0[BITADDR-1:BITVBNK];
  assign rd_bank1 = rd_adr1[BITVBNK-1:0];
  assign rd_row1  = rd_adr1[BITADDR-1:BITVBNK];

  assign wr_ok = ready && write;
  assign rd_ok = read & {NUMRDPT{ready && !write}};

  // port 1 loses the bank to port 0 and rebuilds from the others
  assign rebuild = (&rd_ok) && (rd_bank0 == rd_bank1) && (rd_row0 != rd_row1);

  always_comb begin
    for (int i = 0; i < NUMVBNK; i++) begin
      bank_rd[i] = sweep                                                   // write-first gives zero
                   || (wr_ok && (wr_bank != vbank_t'(i)))                  // old words for parity
                   || (rd_ok[0] && (rd_bank0 == vbank_t'(i)))
                   || (rd_ok[1] && (rebuild ? (rd_bank1 != vbank_t'(i))
                                            : (rd_bank1 == vbank_t'(i))));
      bank_wr[i] = sweep || (wr_ok && (wr_bank == vbank_t'(i)));
      if (sweep) begin
        bank_rd_row[i] = init_row;
      end else if (wr_ok) begin
        bank_rd_row[i] = wr_row;
      end else if (rd_ok[0] && (rd_bank0 == vbank_t'(i))) begin
        bank_rd_row[i] = rd_row0;
      end else begin
        bank_rd_row[i] = rd_row1;
      end
    end
  end

  assign bank_wr_row = sweep ? init_row : wr_row;
  assign bank_wdata  = sweep ? '0 : din;

  for (genvar i = 0; i < NUMVBNK; i++) begin : g_issue
    assign data_bank[i].rd     = bank_rd[i];
    assign data_bank[i].rd_row = bank_rd_row[i];
    assign data_bank[i].wr     = bank_wr[i];
    assign data_bank[i].wr_row = bank_wr_row;
    assign data_bank[i].wdata  = bank_wdata;
  end

  assign par_rd.rd     = rebuild;
  assign par_rd.rd_row = rd_row1;

  assign upd      = sweep || wr_ok;
  assign upd_bank = sweep ? '0 : wr_bank;
  assign upd_row  = bank_wr_row;
  assign upd_data = bank_wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_vld     <= '0;
      pend_rebuild <= '0;
    end else begin
      pend_vld     <= rd_ok;
      pend_rebuild <= {rebuild, 1'b0};  // port 0 always reads directly
    end
  end

  always_ff @(posedge clk) begin
    pend_bank0 <= rd_bank0;
    pend_bank1 <= rd_bank1;
  end

  a_no_read_with_write: assert property (
    @(posedge clk) disable iff (reset) ready |-> !(write && (|read))
  );

endmodule

`default_nettype wire

//--- logic/parity_update.sv
`timescale 1ns/1ps
`default_nettype none

module parity_update (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 upd,
  input  mem2r1w_pkg::vbank_t  upd_bank,
  input  mem2r1w_pkg::vrow_t   upd_row,
  input  mem2r1w_pkg::word_t   upd_data,
  bank_if.ret                  data_ret [mem2r1w_pkg::NUMVBNK],
  bank_if.wr_req               par_wr
);
  import mem2r1w_pkg::*;

  logic   upd_q;
  vbank_t bank_q;
  vrow_t  row_q;
  word_t  data_q;
  word_t  ret_word [NUMVBNK];
  word_t  parity;

  always_ff @(posedge clk) begin
    if (reset) begin
      upd_q <= 1'b0;
    end else begin
      upd_q <= upd;
    end
  end

  always_ff @(posedge clk) begin
    bank_q <= upd_bank;
    row_q  <= upd_row;
    data_q <= upd_data;
  end

  for (genvar i = 0; i < NUMVBNK; i++) begin : g_ret
    assign ret_word[i] = data_ret[i].rdata;
  end

  // the written bank contributes its new word, the rest their current words
  always_comb begin
    parity = data_q;
    for (int i = 0; i < NUMVBNK; i++) begin
      if (vbank_t'(i) != bank_q) begin
        parity = parity ^ ret_word[i];
      end
    end
  end

  assign par_wr.wr     = upd_q;
  assign par_wr.wr_row = row_q;
  assign par_wr.wdata  = parity;

  a_par_follows_upd: assert property (
    @(posedge clk) disable iff (reset) upd |=> par_wr.wr
  );

  a_par_only_after_upd: assert property (
    @(posedge clk) disable iff (reset) !upd |=> !par_wr.wr
  );

endmodule

`default_nettype wire

//--- logic/read_rebuild.sv
`timescale 1ns/1ps
`default_nettype none

module read_rebuild (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [mem2r1w_pkg::NUMRDPT-1:0]  pend_vld,
  input  logic [mem2r1w_pkg::NUMRDPT-1:0]  pend_rebuild,
  input  mem2r1w_pkg::vbank_t              pend_bank0,
  input  mem2r1w_pkg::vbank_t              pend_bank1,
  bank_if.ret                              bank_ret [mem2r1w_pkg::NUMBANK],
  output logic [mem2r1w_pkg::NUMRDPT-1:0]  rd_vld,
  output mem2r1w_pkg::word_t               rd_dout0,
  output mem2r1w_pkg::word_t               rd_dout1
);
  import mem2r1w_pkg::*;

  word_t  bank_word [NUMBANK];
  vbank_t port_bank [NUMRDPT];
  word_t  port_word [NUMRDPT];

  for (genvar i = 0; i < NUMBANK; i++) begin : g_ret
    assign bank_word[i] = bank_ret[i].rdata;
  end

  assign port_bank[0] = pend_bank0;
  assign port_bank[1] = pend_bank1;

  always_comb begin
    word_t rebuilt;
    for (int p = 0; p < NUMRDPT; p++) begin
      rebuilt = bank_word[NUMVBNK];  // start from parity
      for (int i = 0; i < NUMVBNK; i++) begin
        if (vbank_t'(i) != port_bank[p]) begin
          rebuilt = rebuilt ^ bank_word[i];
        end
      end
      port_word[p] = pend_rebuild[p] ? rebuilt : bank_word[port_bank[p]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= pend_vld;
    end
  end

  always_ff @(posedge clk) begin
    rd_dout0 <= port_word[0];
    rd_dout1 <= port_word[1];
  end

endmodule

`default_nettype wire

//--- logic/mem2r1w_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem2r1w_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             write,
  input  mem2r1w_pkg::vaddr_t              wr_adr,
  input  mem2r1w_pkg::word_t               din,
  input  logic [mem2r1w_pkg::NUMRDPT-1:0]  read,
  input  mem2r1w_pkg::vaddr_t              rd_adr0,
  input  mem2r1w_pkg::vaddr_t              rd_adr1,
  output logic                             ready,
  output logic [mem2r1w_pkg::NUMRDPT-1:0]  rd_vld,
  output mem2r1w_pkg::word_t               rd_dout0,
  output mem2r1w_pkg::word_t               rd_dout1
);
  import mem2r1w_pkg::*;

  logic               upd;
  vbank_t             upd_bank;
  vrow_t              upd_row;
  word_t              upd_data;
  logic [NUMRDPT-1:0] pend_vld;
  logic [NUMRDPT-1:0] pend_rebuild;
  vbank_t             pend_bank0;
  vbank_t             pend_bank1;

  bank_if bank [NUMBANK] ();  // last one holds the parity

  for (genvar b = 0; b < NUMBANK; b++) begin : g_bank
    bank_ram bank_i (
      .clk  (clk),
      .port (bank[b])
    );
  end

  access_sched sched_i (
    .clk          (clk),
    .reset        (reset),
    .write        (write),
    .wr_adr       (wr_adr),
    .din          (din),
    .read         (read),
    .rd_adr0      (rd_adr0),
    .rd_adr1      (rd_adr1),
    .ready        (ready),
    .data_bank    (bank[0:NUMVBNK-1]),
    .par_rd       (bank[NUMVBNK]),
    .upd          (upd),
    .upd_bank     (upd_bank),
    .upd_row      (upd_row),
    .upd_data     (upd_data),
    .pend_vld     (pend_vld),
    .pend_rebuild (pend_rebuild),
    .pend_bank0   (pend_bank0),
    .pend_bank1   (pend_bank1)
  );

  parity_update parity_i (
    .clk      (clk),
    .reset    (reset),
    .upd      (upd),
    .upd_bank (upd_bank),
    .upd_row  (upd_row),
    .upd_data (upd_data),
    .data_ret (bank[0:NUMVBNK-1]),
    .par_wr   (bank[NUMVBNK])
  );

  read_rebuild rebuild_i (
    .clk          (clk),
    .reset        (reset),
    .pend_vld     (pend_vld),
    .pend_rebuild (pend_rebuild),
    .pend_bank0   (pend_bank0),
    .pend_bank1   (pend_bank1),
    .bank_ret     (bank),
    .rd_vld       (rd_vld),
    .rd_dout0     (rd_dout0),
    .rd_dout1     (rd_dout1)
  );

endmodule

`default_nettype wire

//--- dv/mem2r1w_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem2r1w_tb;
  import mem2r1w_pkg::*;

  typedef struct packed {
    logic [2:0]         tid;   // which behavior the step exercises
    logic               wr;
    logic [NUMRDPT-1:0] rd;
    vaddr_t             adr0;  // write address or port 0 read address
    vaddr_t             adr1;
  } step_t;

  typedef struct packed {
    logic [2:0]  tid;
    logic [31:0] stamp;  // cycle in which the read was accepted
    word_t       data;
  } pend_t;

  logic               clk = 1'b0;
  logic               reset;
  logic               write;
  vaddr_t             wr_adr;
  word_t              din;
  logic [NUMRDPT-1:0] read;
  vaddr_t             rd_adr0;
  vaddr_t             rd_adr1;
  logic               ready;
  logic [NUMRDPT-1:0] rd_vld;
  word_t              rd_dout0;
  word_t              rd_dout1;

  step_t steps [$];
  pend_t port_q0 [$];
  pend_t port_q1 [$];
  word_t model [2**BITADDR];  // reference contents by virtual address
  int    cycle_cnt = 0;
  int    cycle_limit = 0;
  int    ready_low = 0;
  logic  ready_seen = 1'b0;
  int    checks = 0;
  int    errors = 0;

  mem2r1w_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .read     (read),
    .rd_adr0  (rd_adr0),
    .rd_adr1  (rd_adr1),
    .ready    (ready),
    .rd_vld   (rd_vld),
    .rd_dout0 (rd_dout0),
    .rd_dout1 (rd_dout1)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  function automatic vaddr_t make_adr(input int row, input int bank);
    return vaddr_t'(row * NUMVBNK + bank);  // bank in the low bits
  endfunction

  function automatic string test_name(input logic [2:0] tid);
    case (tid)
      3'd1: return "init_zero";
      3'd2: return "write_then_read";
      3'd3: return "diff_banks";
      3'd4: return "same_bank_rebuild";
      3'd5: return "back_to_back";
      3'd6: return "write_before_ready";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic add_step(input int tid, input logic wr, input logic [NUMRDPT-1:0] rd,
                          input vaddr_t adr0, input vaddr_t adr1);
    step_t s;
    s.tid  = 3'(tid);
    s.wr   = wr;
    s.rd   = rd;
    s.adr0 = adr0;
    s.adr1 = adr1;
    steps.push_back(s);
  endtask

  // drives one step and records what each accepted read has to return
  task automatic apply_step(input step_t s);
    word_t data;
    pend_t ent;
    data      = word_t'($urandom);
    write     <= s.wr;
    wr_adr    <= s.adr0;
    din       <= data;
    read      <= s.wr ? '0 : s.rd;
    rd_adr0   <= s.adr0;
    rd_adr1   <= s.adr1;
    ent.tid   = s.tid;
    ent.stamp = 32'(cycle_cnt);
    ent.data  = '0;
    if (s.wr) begin
      model[s.adr0] = data;
    end else begin
      if (s.rd[0]) begin
        ent.data = model[s.adr0];
        port_q0.push_back(ent);
      end
      if (s.rd[1]) begin
        ent.data = model[s.adr1];
        port_q1.push_back(ent);
      end
    end
  endtask

  task automatic match_read(input int port, input pend_t ent, input word_t dout);
    string name;
    name = $sformatf("%s port%0d", test_name(ent.tid), port);
    check_value({name, " data"}, 32'(ent.data), 32'(dout));
    check_value({name, " latency"}, 32'd2, 32'(cycle_cnt) - ent.stamp);
  endtask

  task automatic report_counts();
    $display("checks %0d, errors %0d, reads outstanding %0d", checks, errors,
             port_q0.size() + port_q1.size());
  endtask

  // outputs are sampled half a cycle away from the driving edge
  always @(negedge clk) begin
    if (rd_vld[0]) begin
      if (port_q0.size() == 0) begin
        errors++;
        $display("port 0 returned data for a read that was never issued");
      end else begin
        match_read(0, port_q0.pop_front(), rd_dout0);
      end
    end
    if (rd_vld[1]) begin
      if (port_q1.size() == 0) begin
        errors++;
        $display("port 1 returned data for a read that was never issued");
      end else begin
        match_read(1, port_q1.pop_front(), rd_dout1);
      end
    end
    if (!reset) begin
      if (ready) begin
        ready_seen = 1'b1;
      end else if (ready_seen) begin
        errors++;
        $display("ready dropped after the init sweep had finished");
      end else begin
        ready_low++;
      end
    end
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycle_limit);
      report_counts();
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h1e4b));
    reset   = 1'b1;
    write   = 1'b0;
    wr_adr  = '0;
    din     = '0;
    read    = '0;
    rd_adr0 = '0;
    rd_adr1 = '0;
    for (int a = 0; a < 2**BITADDR; a++) begin
      model[a] = '0;
    end

    add_step(1, 1'b0, 2'b11, make_adr(3, 1), make_adr(7, 2));
    add_step(1, 1'b0, 2'b11, make_adr(0, 0), make_adr(15, 3));
    add_step(1, 1'b0, 2'b11, make_adr(4, 2), make_adr(9, 2));
    add_step(6, 1'b0, 2'b11, make_adr(0, 1), make_adr(0, 1));
    add_step(2, 1'b1, 2'b00, make_adr(2, 1), '0);
    add_step(2, 1'b0, 2'b01, make_adr(2, 1), '0);
    add_step(2, 1'b1, 2'b00, make_adr(6, 3), '0);
    add_step(2, 1'b0, 2'b10, '0, make_adr(6, 3));
    add_step(3, 1'b1, 2'b00, make_adr(2, 0), '0);
    add_step(3, 1'b1, 2'b00, make_adr(2, 2), '0);
    add_step(3, 1'b0, 2'b11, make_adr(2, 0), make_adr(2, 2));
    add_step(3, 1'b0, 2'b11, make_adr(2, 1), make_adr(6, 3));
    add_step(4, 1'b1, 2'b00, make_adr(8, 1), '0);
    add_step(4, 1'b0, 2'b11, make_adr(2, 1), make_adr(8, 1));
    add_step(4, 1'b0, 2'b11, make_adr(8, 1), make_adr(2, 1));
    add_step(5, 1'b1, 2'b00, make_adr(5, 0), '0);
    add_step(5, 1'b1, 2'b00, make_adr(5, 1), '0);
    add_step(5, 1'b1, 2'b00, make_adr(5, 2), '0);
    add_step(5, 1'b1, 2'b00, make_adr(5, 3), '0);
    add_step(5, 1'b0, 2'b11, make_adr(2, 3), make_adr(5, 3));  // parity row is one cycle old
    add_step(5, 1'b0, 2'b11, make_adr(5, 2), make_adr(2, 2));
    add_step(5, 1'b0, 2'b11, make_adr(2, 0), make_adr(5, 0));
    add_step(5, 1'b0, 2'b11, make_adr(5, 1), make_adr(8, 1));
    add_step(5, 1'b0, 2'b11, make_adr(9, 1), make_adr(5, 1));
    cycle_limit = (steps.size() + NUMVROW + 20) * 2;

    repeat (3) @(posedge clk);
    reset  <= 1'b0;
    write  <= 1'b1;  // held over the whole sweep, after row 0 is already zeroed
    wr_adr <= make_adr(0, 1);
    din    <= 16'hbeef;
    repeat (NUMVROW) @(posedge clk);
    write <= 1'b0;
    while (!ready) @(negedge clk);
    check_value("init_zero ready low cycles", 32'(NUMVROW), 32'(ready_low));

    foreach (steps[i]) begin
      @(posedge clk);
      apply_step(steps[i]);
    end
    @(posedge clk);
    write <= 1'b0;
    read  <= '0;
    while ((port_q0.size() + port_q1.size()) != 0) @(negedge clk);
    repeat (4) @(negedge clk);  // no stray rd_vld may follow

    report_counts();
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mem2r1w.f
logic/mem2r1w_pkg.sv
logic/bank_if.sv
logic/bank_ram.sv
logic/access_sched.sv
logic/parity_update.sv
logic/read_rebuild.sv
logic/mem2r1w_top.sv
dv/mem2r1w_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mem2r1w_tb \
  -f mem2r1w.f -Mdir obj_dir -o mem2r1w_sim \
  && ./obj_dir/mem2r1w_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
